// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // ==========================================================
  // Instruction classes
  // ==========================================================
  localparam logic [2:0] CLS_DP_IMM     = 3'd0;
  localparam logic [2:0] CLS_DP_REG_IMM = 3'd1;
  localparam logic [2:0] CLS_LOAD       = 3'd2;
  localparam logic [2:0] CLS_STORE      = 3'd3;
  localparam logic [2:0] CLS_OTHER      = 3'd4;

  // ALU opcodes use the values of the ARM opcode field
  localparam logic [3:0] ALU_AND = 4'h0;
  localparam logic [3:0] ALU_EOR = 4'h1;
  localparam logic [3:0] ALU_SUB = 4'h2;
  localparam logic [3:0] ALU_ADD = 4'h4;
  localparam logic [3:0] ALU_CMP = 4'hA;
  localparam logic [3:0] ALU_ORR = 4'hC;
  localparam logic [3:0] ALU_MOV = 4'hD;

  // ==========================================================
  // Datapath selects
  // ==========================================================
  localparam logic [1:0] ADDR_SRC_PC   = 2'd0;
  localparam logic [1:0] ADDR_SRC_INCR = 2'd1;
  localparam logic [1:0] ADDR_SRC_ALU  = 2'd2;

  localparam logic B_SRC_IMM = 1'b0;
  localparam logic B_SRC_RM  = 1'b1;

  localparam logic [1:0] WB_NONE   = 2'd0;
  localparam logic [1:0] WB_RD     = 2'd1;
  localparam logic [1:0] WB_RN     = 2'd2;
  localparam logic [1:0] WB_MEM_RD = 2'd3;

  localparam logic [1:0] SHIFT_LSL = 2'd0;
  localparam logic [1:0] SHIFT_LSR = 2'd1;
  localparam logic [1:0] SHIFT_ASR = 2'd2;
  localparam logic [1:0] SHIFT_ROR = 2'd3;

  localparam logic [2:0]  FLUSH_CYCLES = 3'd3;
  localparam logic [31:0] PC_RESET     = 32'h0;

  // SWI encoding that decodes as CLS_OTHER and only fetches on
  localparam logic [31:0] INSTR_NOP = 32'hEF00_0000;

  // ==========================================================
  // Instruction word with data processing and load/store views
  // ==========================================================
  typedef union packed {
    struct packed {
      logic [3:0]  cond;
      logic [1:0]  op_class;
      logic        imm_flag;
      logic [3:0]  opcode;
      logic        set_flags;
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] operand2;
    } dp;
    struct packed {
      logic [3:0]  cond;
      logic [1:0]  op_class;
      logic        imm_flag;
      logic        pre;
      logic        up;
      logic        byte_xfer;
      logic        wback;
      logic        load;
      logic [3:0]  rn;
      logic [3:0]  rd;
      logic [11:0] offset;
    } ls;
  } instr_word_u;

endpackage

`default_nettype wire

// File: decoder_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decoder_if import cpu_pkg::*; ();

  // Load strobe from the control unit
  logic        enable;

  // Current instruction and its decoded fields
  instr_word_u instr;
  logic [2:0]  instr_class;
  logic [3:0]  rd;
  logic [3:0]  rn;
  logic [3:0]  rm;

  modport decoder_side (
    input  enable,
    output instr, instr_class, rd, rn, rm
  );

  modport control_side (
    output enable,
    input  instr, instr_class
  );

endinterface

`default_nettype wire

// File: ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if ();

  // Bus and operand selection
  logic [1:0]  addr_src;
  logic        b_src;
  logic [11:0] b_imm;
  logic [1:0]  shift_type;
  logic [4:0]  shift_amount;
  logic [3:0]  alu_op;
  logic [1:0]  wb_target;

  // PC increment and offset latch handling
  logic        incr_writeback;
  logic        latch_op_b;
  logic        use_op_b_latch;
  logic        disable_op_b;

  // Memory strobes
  logic        mem_read_en;
  logic        mem_write_en;

  modport control_side (
    output addr_src, b_src, b_imm, shift_type, shift_amount, alu_op, wb_target,
    output incr_writeback, latch_op_b, use_op_b_latch, disable_op_b,
    output mem_read_en, mem_write_en
  );

  modport datapath_side (
    input addr_src, b_src, b_imm, shift_type, shift_amount, alu_op, wb_target,
    input incr_writeback, latch_op_b, use_op_b_latch, disable_op_b,
    input mem_read_en, mem_write_en
  );

endinterface

`default_nettype wire

// File: instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import cpu_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  decoder_if.decoder_side    dec,
  input  logic [31:0]        mem_rdata
);

  instr_word_u ir;
  logic [2:0]  instr_class;

  // Instruction register loaded only on a fetch
  always_ff @(posedge clk) begin
    if (reset) begin
      ir <= INSTR_NOP;
    end else if (dec.enable) begin
      ir <= mem_rdata;
    end
  end

  // Classification from bits 27:25, the load bit and bit 4
  always_comb begin
    instr_class = CLS_OTHER;
    case (ir.dp.op_class)
      2'b00: begin
        if (ir.dp.imm_flag) begin
          instr_class = CLS_DP_IMM;
        end else if (!ir.dp.operand2[4]) begin
          // Bit 4 set means shift by register or multiply
          instr_class = CLS_DP_REG_IMM;
        end
      end
      2'b01: begin
        // Only word transfers with an immediate offset
        if (!ir.ls.imm_flag && !ir.ls.byte_xfer) begin
          instr_class = ir.ls.load ? CLS_LOAD : CLS_STORE;
        end
      end
      default: instr_class = CLS_OTHER;
    endcase
  end

  assign dec.instr       = ir;
  assign dec.instr_class = instr_class;
  assign dec.rd          = ir.dp.rd;
  assign dec.rn          = ir.dp.rn;
  assign dec.rm          = ir.dp.operand2[3:0];

endmodule

`default_nettype wire

// File: control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit import cpu_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  decoder_if.control_side  dec,
  ctrl_if.control_side     ctrl
);

  logic [2:0]  flush_cnt;
  logic [1:0]  cycle;
  logic        flushing;
  logic        instr_done;
  logic        base_wb;
  instr_word_u ir;

  assign ir       = dec.instr;
  assign flushing = (flush_cnt != 3'd0);
  // Post-indexed transfers always update the base
  assign base_wb  = !ir.ls.pre || ir.ls.wback;

  // A new instruction is latched exactly when the current one ends
  assign dec.enable = instr_done;

  // CMP and opcodes outside the subset leave the registers alone
  function automatic logic [1:0] dp_wb_target(input logic [3:0] opcode);
    case (opcode)
      ALU_AND, ALU_EOR, ALU_SUB, ALU_ADD, ALU_ORR, ALU_MOV: return WB_RD;
      default: return WB_NONE;
    endcase
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      flush_cnt <= FLUSH_CYCLES;
    end else if (flushing) begin
      flush_cnt <= flush_cnt - 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || flushing || instr_done) begin
      cycle <= 2'd0;
    end else begin
      cycle <= cycle + 2'd1;
    end
  end

  always_comb begin
    ctrl.addr_src       = ADDR_SRC_PC;
    ctrl.b_src          = B_SRC_IMM;
    ctrl.b_imm          = 12'd0;
    ctrl.shift_type     = SHIFT_LSL;
    ctrl.shift_amount   = 5'd0;
    ctrl.alu_op         = ALU_MOV;
    ctrl.wb_target      = WB_NONE;
    ctrl.incr_writeback = 1'b0;
    ctrl.latch_op_b     = 1'b0;
    ctrl.use_op_b_latch = 1'b0;
    ctrl.disable_op_b   = 1'b0;
    ctrl.mem_read_en    = 1'b0;
    ctrl.mem_write_en   = 1'b0;
    instr_done          = 1'b0;

    if (flushing) begin
      // ==========================================================
      // Start-up flush
      // ==========================================================
      case (flush_cnt)
        FLUSH_CYCLES: ctrl.addr_src = ADDR_SRC_PC;
        3'd2:         ctrl.mem_read_en = 1'b1;
        default:      instr_done = 1'b1;
      endcase
    end else begin
      case (dec.instr_class)
        CLS_DP_IMM: begin
          // imm8 rotated right by twice the rotate field
          ctrl.b_src        = B_SRC_IMM;
          ctrl.b_imm        = {4'd0, ir.dp.operand2[7:0]};
          ctrl.shift_type   = SHIFT_ROR;
          ctrl.shift_amount = {ir.dp.operand2[11:8], 1'b0};
          ctrl.alu_op       = ir.dp.opcode;
          ctrl.wb_target    = dp_wb_target(ir.dp.opcode);
          instr_done        = 1'b1;
        end

        CLS_DP_REG_IMM: begin
          ctrl.b_src        = B_SRC_RM;
          ctrl.shift_type   = ir.dp.operand2[6:5];
          ctrl.shift_amount = ir.dp.operand2[11:7];
          ctrl.alu_op       = ir.dp.opcode;
          ctrl.wb_target    = dp_wb_target(ir.dp.opcode);
          instr_done        = 1'b1;
        end

        CLS_LOAD, CLS_STORE: begin
          ctrl.b_src  = B_SRC_IMM;
          ctrl.b_imm  = ir.ls.offset;
          ctrl.alu_op = ir.ls.up ? ALU_ADD : ALU_SUB;
          if (cycle == 2'd0) begin
            // Memory access, offset kept for the base update
            ctrl.addr_src     = ADDR_SRC_ALU;
            ctrl.latch_op_b   = 1'b1;
            ctrl.disable_op_b = !ir.ls.pre;
            if (dec.instr_class == CLS_LOAD) begin
              ctrl.mem_read_en = 1'b1;
              ctrl.wb_target   = WB_MEM_RD;
            end else begin
              ctrl.mem_write_en = 1'b1;
            end
          end else begin
            if (base_wb) begin
              ctrl.use_op_b_latch = 1'b1;
              ctrl.wb_target      = WB_RN;
            end
            instr_done = 1'b1;
          end
        end

        default: instr_done = 1'b1;
      endcase
    end

    // Fetch of the next instruction
    if (instr_done) begin
      ctrl.addr_src       = ADDR_SRC_PC;
      ctrl.mem_read_en    = 1'b1;
      ctrl.incr_writeback = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath import cpu_pkg::*; (
  input  logic                clk,
  input  logic                reset,
  ctrl_if.datapath_side       ctrl,
  input  logic [3:0]          rn_idx,
  input  logic [3:0]          rd_idx,
  input  logic [3:0]          rm_idx,
  input  logic [31:0]         mem_rdata,
  output logic [31:0]         mem_addr,
  output logic [31:0]         mem_wdata,
  output logic                mem_read_en,
  output logic                mem_write_en
);

  logic [31:0] regs [0:14];
  logic [31:0] pc;
  logic [31:0] pc_incr;
  logic [31:0] rn_val;
  logic [31:0] rd_val;
  logic [31:0] rm_val;
  logic [31:0] b_bus;
  logic [63:0] ror_dbl;
  logic [31:0] b_shifted;
  logic [31:0] op_b;
  logic [31:0] op_b_latch;
  logic [31:0] alu_result;
  logic [31:0] addr_bus;

  // Index 15 reads the PC
  assign rn_val  = (rn_idx == 4'd15) ? pc : regs[rn_idx];
  assign rd_val  = (rd_idx == 4'd15) ? pc : regs[rd_idx];
  assign rm_val  = (rm_idx == 4'd15) ? pc : regs[rm_idx];
  assign pc_incr = pc + 32'd4;

  // ==========================================================
  // B bus and barrel shifter
  // ==========================================================
  assign b_bus   = (ctrl.b_src == B_SRC_RM) ? rm_val : {20'd0, ctrl.b_imm};
  assign ror_dbl = {b_bus, b_bus} >> ctrl.shift_amount;

  always_comb begin
    case (ctrl.shift_type)
      SHIFT_LSL: b_shifted = b_bus << ctrl.shift_amount;
      SHIFT_LSR: b_shifted = b_bus >> ctrl.shift_amount;
      SHIFT_ASR: b_shifted = $signed(b_bus) >>> ctrl.shift_amount;
      SHIFT_ROR: b_shifted = ror_dbl[31:0];
      default:   b_shifted = b_bus;
    endcase
  end

  // Offset kept from the access cycle for the base update
  always_ff @(posedge clk) begin
    if (ctrl.latch_op_b) begin
      op_b_latch <= b_shifted;
    end
  end

  assign op_b = ctrl.use_op_b_latch ? op_b_latch : b_shifted;

  // ==========================================================
  // ALU
  // ==========================================================
  always_comb begin
    if (ctrl.disable_op_b) begin
      alu_result = rn_val;
    end else begin
      case (ctrl.alu_op)
        ALU_AND:          alu_result = rn_val & op_b;
        ALU_EOR:          alu_result = rn_val ^ op_b;
        ALU_SUB, ALU_CMP: alu_result = rn_val - op_b;
        ALU_ADD:          alu_result = rn_val + op_b;
        ALU_ORR:          alu_result = rn_val | op_b;
        ALU_MOV:          alu_result = op_b;
        default:          alu_result = 32'd0;
      endcase
    end
  end

  always_comb begin
    case (ctrl.addr_src)
      ADDR_SRC_INCR: addr_bus = pc_incr;
      ADDR_SRC_ALU:  addr_bus = alu_result;
      default:       addr_bus = pc;
    endcase
  end

  // Register file and PC
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= PC_RESET;
      for (int i = 0; i < 15; i++) begin
        regs[i] <= 32'd0;
      end
    end else begin
      if (ctrl.incr_writeback) begin
        pc <= pc_incr;
      end
      case (ctrl.wb_target)
        WB_RD:     if (rd_idx != 4'd15) regs[rd_idx] <= alu_result;
        WB_RN:     if (rn_idx != 4'd15) regs[rn_idx] <= alu_result;
        WB_MEM_RD: if (rd_idx != 4'd15) regs[rd_idx] <= mem_rdata;
        default:   ;
      endcase
    end
  end

  assign mem_addr     = addr_bus;
  assign mem_wdata    = rd_val;
  assign mem_read_en  = ctrl.mem_read_en;
  assign mem_write_en = ctrl.mem_write_en;

endmodule

`default_nettype wire

// File: cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
  input  logic        clk,
  input  logic        reset,
  input  logic [31:0] mem_rdata,
  output logic [31:0] mem_addr,
  output logic        mem_read_en,
  output logic        mem_write_en,
  output logic [31:0] mem_wdata
);

  decoder_if dec_bus ();
  ctrl_if    ctrl_bus ();

  instr_decoder u_decoder (
    .clk       (clk),
    .reset     (reset),
    .dec       (dec_bus),
    .mem_rdata (mem_rdata)
  );

  control_unit u_control (
    .clk   (clk),
    .reset (reset),
    .dec   (dec_bus),
    .ctrl  (ctrl_bus)
  );

  // Register indices come straight from the decoded instruction
  datapath u_datapath (
    .clk          (clk),
    .reset        (reset),
    .ctrl         (ctrl_bus),
    .rn_idx       (dec_bus.rn),
    .rd_idx       (dec_bus.rd),
    .rm_idx       (dec_bus.rm),
    .mem_rdata    (mem_rdata),
    .mem_addr     (mem_addr),
    .mem_wdata    (mem_wdata),
    .mem_read_en  (mem_read_en),
    .mem_write_en (mem_write_en)
  );

endmodule

`default_nettype wire

// File: cpu_core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core_assert (
  input logic clk,
  input logic reset,
  input logic mem_read_en,
  input logic mem_write_en,
  input logic fetch_en
);

  int unsigned failures = 0;

  // Memory is either read or written in a cycle
  strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(mem_read_en && mem_write_en))
    else begin
      $error("Read and write strobes high in the same cycle");
      failures++;
    end

  strobes_low_in_reset: assert property (@(posedge clk)
    (reset && $past(reset)) |-> (!mem_read_en && !mem_write_en))
    else begin
      $error("Memory strobe high while reset is held");
      failures++;
    end

  // A fetch ends an instruction and never stores
  no_write_on_fetch: assert property (@(posedge clk) disable iff (reset)
    fetch_en |-> !mem_write_en)
    else begin
      $error("Write strobe high in a fetch cycle");
      failures++;
    end

endmodule

bind cpu_core cpu_core_assert u_checks (
  .clk          (clk),
  .reset        (reset),
  .mem_read_en  (mem_read_en),
  .mem_write_en (mem_write_en),
  .fetch_en     (dec_bus.enable)
);

`default_nettype wire

// File: tb_cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core import cpu_pkg::*; ();

  logic        clk;
  logic        reset;
  logic [31:0] mem_rdata;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic        mem_read_en;
  logic        mem_write_en;

  // Memory image and the raw contents of the test file
  logic [31:0] mem [0:63];
  logic [31:0] test_words [0:127];

  int unsigned prog_len;
  int unsigned write_total;
  int unsigned writes_seen;
  int unsigned cycle_count;
  int unsigned cycle_limit;
  bit          first_read_seen;
  bit          first_fetch_seen;
  bit          instr_checked;

  cpu_core UUT (
    .clk          (clk),
    .reset        (reset),
    .mem_rdata    (mem_rdata),
    .mem_addr     (mem_addr),
    .mem_read_en  (mem_read_en),
    .mem_write_en (mem_write_en),
    .mem_wdata    (mem_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ==========================================================
  // Memory model with combinational read and write on the edge
  // ==========================================================
  assign mem_rdata = mem[mem_addr[7:2]];

  always @(posedge clk) begin
    if (mem_write_en === 1'b1) begin
      mem[mem_addr[7:2]] <= mem_wdata;
    end
  end

  // Unused words hold an SWI tagged with its own byte address
  function automatic logic [31:0] fill_word(input int unsigned idx);
    return 32'hEF00_0000 | (idx << 2);
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic compare_word(input logic [31:0] actual, input logic [31:0] expected,
                              input string name);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Fail at %0d ns: %s is %h, expected %h",
                                  $time, name, actual, expected));
    end
  endtask

  task automatic compare_instr(input instr_word_u actual, input instr_word_u expected,
                               input string name);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Fail at %0d ns: %s is %h, expected %h",
                                  $time, name, actual, expected));
    end
  endtask

  // Words 40 and 41 hold the program length and the write count before the pairs
  task automatic load_tests();
    $readmemh("cpu_tests.txt", test_words);
    if ($isunknown(test_words['h40]) || $isunknown(test_words['h41])) begin
      stop_with_failure("cpu_tests.txt is missing or lacks its length and count words");
    end
    prog_len    = test_words['h40];
    write_total = test_words['h41];
    if (prog_len == 0 || prog_len > 64 || write_total == 0 || write_total > 31) begin
      stop_with_failure("cpu_tests.txt gives a program length or write count out of range");
    end
    for (int i = 0; i < 64; i++) begin
      mem[i] = $isunknown(test_words[i]) ? fill_word(i) : test_words[i];
    end
    cycle_limit = 4 * prog_len + FLUSH_CYCLES;
  endtask

  // ==========================================================
  // Main sequence
  // ==========================================================
  initial begin
    reset            = 1'b1;
    first_read_seen  = 1'b0;
    first_fetch_seen = 1'b0;
    instr_checked    = 1'b0;
    writes_seen      = 0;
    cycle_count      = 0;
    load_tests();

    repeat (10) @(posedge clk);
    reset <= 1'b0;

    while (writes_seen < write_total) begin
      @(negedge clk);
      cycle_count++;
      if (cycle_count > cycle_limit) begin
        stop_with_failure($sformatf("Timeout after %0d cycles with %0d of %0d writes seen",
                                    cycle_count, writes_seen, write_total));
      end
      if (UUT.u_checks.failures != 0) begin
        stop_with_failure("A bound assertion on the core failed");
      end
      // First read after reset comes from address 0
      if (!first_read_seen && mem_read_en === 1'b1) begin
        first_read_seen = 1'b1;
        compare_word(mem_addr, 32'h0000_0000, "mem_addr");
      end
      // The decoder holds the first word one cycle after its load strobe
      if (first_fetch_seen && !instr_checked) begin
        instr_checked = 1'b1;
        compare_instr(UUT.dec_bus.instr, test_words[0], "UUT.dec_bus.instr");
      end
      if (UUT.dec_bus.enable === 1'b1) begin
        first_fetch_seen = 1'b1;
      end
      if (mem_write_en === 1'b1) begin
        compare_word(mem_addr, test_words['h42 + 2 * writes_seen], "mem_addr");
        compare_word(mem_wdata, test_words['h43 + 2 * writes_seen], "mem_wdata");
        writes_seen++;
      end
    end

    // One more edge so the assertions see the last write
    @(negedge clk);
    if (!first_read_seen) begin
      stop_with_failure("The core wrote memory without any read before it");
    end
    if (!instr_checked) begin
      stop_with_failure("The first instruction never reached the decoder");
    end
    if (UUT.u_checks.failures == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("A bound assertion on the core failed in the last cycle");
      $display("Done: errors found");
      $fatal(1, "Simulation stopped");
    end
  end

endmodule

`default_nettype wire

// File: cpu_tests.txt
// Hex words. @00-@3F memory image with the program from @00 and load data at @38
// @40 program length, @41 write count, from @42 expected write address then data
@00
// MOV and ADD with rotated immediates, base r10 = 0x80, stores to 0x80 and 0x84
E3A014FF E2812F3F E3A0A080 E58A1000 E58A2004
// r3 = 0x80000031, then LSL, LSR, ASR, ROR, AND and CMP with Rd field r1
E3A03031 E3833102 E1A04203 E08350A3 E0236243 E1A07463 E0038002 E1541003
// Stores of r4 to r8 and r1
E58A4008 E58A500C E58A6010 E58A7014 E58A8018 E58A101C
// Pre-indexed store with writeback, then a store through the new base
E5AA4020 E58A5004
// Post-indexed load going down from 0xE0, then stores of Rd and the base
E3A090E0 E419B008 E58AB008 E58A900C
@38
12345678
@40
00000019
0000000C
// Expected writes
00000080 FF000000
00000084 FF0000FC
00000088 00000310
0000008C C0000049
00000090 78000032
00000094 31800000
00000098 80000030
0000009C FF000000
000000A0 00000310
000000A4 C0000049
000000A8 12345678
000000AC 000000D8

// File: filelist.f
cpu_pkg.sv
decoder_if.sv
ctrl_if.sv
instr_decoder.sv
control_unit.sv
datapath.sv
cpu_core.sv
cpu_core_assert.sv
tb_cpu_core.sv
